//--- Makefile
# Verilator flow for the fifo_arb testbench
# make run builds the simulator, runs it into sim.log and fails on a failing result

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --top-module tb_fifo_arb -f build.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_fifo_arb > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed, see sim.log"; exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- build.f
logic/router_pkg.sv
logic/trans_fifo.sv
logic/rr_arbiter.sv
logic/winner_reg.sv
logic/fifo_arb.sv
verification/tb_fifo_arb.sv

//--- logic/fifo_arb.sv
// north-bound merge stage top, four neighbor FIFOs into one registered winner
// per-client numbered ports, out_readyN tells neighbor N its FIFO has room
`timescale 1ns/1ps

module fifo_arb (
    input  logic                    clk,
    input  logic                    rst_n,
    // ==================================================
    // new transactions from neighbor tiles
    // ==================================================
    input  logic                    valid_alloc_req0, // push strobes
    input  logic                    valid_alloc_req1,
    input  logic                    valid_alloc_req2,
    input  logic                    valid_alloc_req3,
    input  router_pkg::tile_trans_t alloc_req0,
    input  router_pkg::tile_trans_t alloc_req1,
    input  router_pkg::tile_trans_t alloc_req2,
    input  router_pkg::tile_trans_t alloc_req3,
    output logic                    out_ready0,       // FIFO not full
    output logic                    out_ready1,
    output logic                    out_ready2,
    output logic                    out_ready3,
    // ==================================================
    // toward the next north tile
    // ==================================================
    output router_pkg::tile_trans_t winner_req,
    output logic                    winner_req_valid, // one-cycle pulse, no ack
    input  logic                    in_ready0,        // any high lets the arbiter pop
    input  logic                    in_ready1,
    input  logic                    in_ready2,
    input  logic                    in_ready3
);
    import router_pkg::*;

    tile_trans_t [NUM_CLIENTS-1:0] din;       // push data per client
    tile_trans_t [NUM_CLIENTS-1:0] dout_fifo; // FIFO heads, arbiter candidates
    logic        [NUM_CLIENTS-1:0] push;
    logic        [NUM_CLIENTS-1:0] fifo_pop;  // one-hot from arbiter
    logic        [NUM_CLIENTS-1:0] full;
    logic        [NUM_CLIENTS-1:0] empty;
    logic        [NUM_CLIENTS-1:0] ready_vec;

    // numbered ports onto vectors
    assign push      = {valid_alloc_req3, valid_alloc_req2, valid_alloc_req1, valid_alloc_req0};
    assign din       = {alloc_req3, alloc_req2, alloc_req1, alloc_req0};
    assign ready_vec = {in_ready3, in_ready2, in_ready1, in_ready0};

    // room in FIFO N is the ready level back to neighbor N
    assign out_ready0 = !full[0];
    assign out_ready1 = !full[1];
    assign out_ready2 = !full[2];
    assign out_ready3 = !full[3];

    for (genvar i = 0; i < NUM_CLIENTS; i++) begin : gen_fifo
        trans_fifo u_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[i]),
            .push_data (din[i]),
            .pop       (fifo_pop[i]),  // granted by arbiter
            .pop_data  (dout_fifo[i]),
            .full      (full[i]),
            .empty     (empty[i])
        );
    end

    rr_arbiter u_arb (
        .clk             (clk),
        .rst_n           (rst_n),
        .valid_candidate (~empty),       // non-empty FIFOs compete
        .in_ready        (ready_vec),
        .pop             (fifo_pop)
    );

    winner_reg u_winner (
        .clk              (clk),
        .rst_n            (rst_n),
        .pop              (fifo_pop),
        .candidate        (dout_fifo),
        .winner_req       (winner_req),
        .winner_req_valid (winner_req_valid)
    );

endmodule

//--- logic/router_pkg.sv
// shared types and sizing for the north-bound merge stage of the router tile
// modules import this for the transaction format and client/FIFO sizes
package router_pkg;

    // ==================================================
    // sizing
    // ==================================================
    localparam int NUM_CLIENTS = 4;                   // neighbor tiles feeding the merge
    localparam int FIFO_DEPTH  = 4;                   // entries per client FIFO, power of two
    localparam int CLIENT_ID_W = $clog2(NUM_CLIENTS); // client index width

    // derived FIFO widths
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);     // read/write pointer, wraps naturally
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1); // occupancy, must reach FIFO_DEPTH

    // ==================================================
    // transaction format
    // ==================================================
    typedef enum logic [1:0] {
        OP_ALLOC = 2'd0, // allocate a slot on the destination tile
        OP_FREE  = 2'd1, // release a previous allocation
        OP_READ  = 2'd2,
        OP_WRITE = 2'd3
    } opcode_t;

    // one single-flit transaction, 32 bits total
    // msb first: opcode, source, destination, payload
    typedef struct packed {
        opcode_t     opcode;   // [31:30]
        logic [3:0]  src_tile; // [29:26] originating tile id
        logic [3:0]  dst_tile; // [25:22] target tile id
        logic [21:0] payload;  // [21:0] opaque to this stage
    } tile_trans_t;

endpackage

//--- logic/rr_arbiter.sv
// round-robin arbiter over the client FIFOs, one-hot pop per cycle
// pops only while some downstream ready level is high
`timescale 1ns/1ps

module rr_arbiter (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [router_pkg::NUM_CLIENTS-1:0] valid_candidate, // FIFO not empty
    input  logic [router_pkg::NUM_CLIENTS-1:0] in_ready,        // downstream ready levels
    output logic [router_pkg::NUM_CLIENTS-1:0] pop              // one-hot grant, also FIFO pop
);
    import router_pkg::*;

    logic [CLIENT_ID_W-1:0] prio_ptr; // client with highest priority this cycle
    logic [CLIENT_ID_W-1:0] win_id;   // index of the granted client
    logic                   may_pop;  // someone downstream will take the winner

    // any one ready level is enough to let a winner out
    assign may_pop = |in_ready;

    // ==================================================
    // search from the pointer, wrapping around
    // ==================================================
    always_comb begin : search
        logic [CLIENT_ID_W-1:0] idx;
        logic                   found;
        pop    = '0;
        win_id = prio_ptr;
        found  = 1'b0;
        for (int k = 0; k < NUM_CLIENTS; k++) begin
            idx = prio_ptr + CLIENT_ID_W'(k); // wraps modulo NUM_CLIENTS
            if (!found && may_pop && valid_candidate[idx]) begin
                found       = 1'b1;            // first hit wins, later ones ignored
                win_id      = idx;
                pop[idx]    = 1'b1;
            end
        end
    end

    // pointer moves past the winner only when something was popped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_ptr <= '0;                  // client 0 first after reset
        end else if (|pop) begin
            prio_ptr <= win_id + 1'b1;       // winner drops to lowest priority
        end
    end

    // ==================================================
    // grant checks
    // ==================================================
    // a single FIFO drains per cycle, winner_reg relies on this for its mux
    a_pop_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(pop)
    ) else $error("more than one client granted");

    // grants never reach an empty FIFO and never happen without a taker
    a_pop_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((pop & ~valid_candidate) == '0) && (!may_pop -> (pop == '0))
    ) else $error("grant to invalid candidate or without ready");

endmodule

//--- logic/trans_fifo.sv
// per-client transaction FIFO with combinational head and full/empty flags
// one instance per neighbor tile inside the merge stage
`timescale 1ns/1ps

module trans_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,      // write strobe from neighbor
    input  router_pkg::tile_trans_t push_data,
    input  logic                    pop,       // read strobe from arbiter
    output router_pkg::tile_trans_t pop_data,  // head of queue, valid when !empty
    output logic                    full,
    output logic                    empty
);
    import router_pkg::*;

    tile_trans_t           mem [FIFO_DEPTH]; // circular buffer storage
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;            // number of held entries
    logic                  do_push;
    logic                  do_pop;

    // qualified strobes
    // a push into a full FIFO still goes in when the head leaves this cycle
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    assign full     = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];           // head shown combinationally

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // both or neither, level unchanged
            endcase
        end
    end

    // ==================================================
    // protocol checks
    // ==================================================
    // neighbor must honor out_ready, so a push at full needs a same-cycle pop
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (push && full) |-> pop
    ) else $error("push into full FIFO dropped");

    // arbiter only grants non-empty clients
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> !empty
    ) else $error("pop from empty FIFO");

endmodule

//--- logic/winner_reg.sv
// output stage, picks the granted FIFO head and registers it
// winner_req_valid is a one-cycle pulse per popped item
`timescale 1ns/1ps

module winner_reg (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [router_pkg::NUM_CLIENTS-1:0]                  pop,       // one-hot grant
    input  router_pkg::tile_trans_t [router_pkg::NUM_CLIENTS-1:0] candidate, // FIFO heads
    output router_pkg::tile_trans_t                             winner_req,
    output logic                                                winner_req_valid
);
    import router_pkg::*;

    tile_trans_t sel_req; // head of the granted client

    // one-hot mux, pop has at most one bit set
    always_comb begin
        sel_req = '0;
        for (int k = 0; k < NUM_CLIENTS; k++) begin
            if (pop[k]) sel_req = candidate[k];
        end
    end

    // payload only loads on a pop, holds otherwise
    always_ff @(posedge clk) begin
        if (|pop) winner_req <= sel_req;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) winner_req_valid <= 1'b0;
        else        winner_req_valid <= |pop; // pulse follows the pop by one cycle
    end

    // a popped item is never lost between FIFO and the next tile
    a_pop_then_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        |pop |=> winner_req_valid
    ) else $error("pop not followed by valid winner");

endmodule

//--- verification/fifo_arb_golden.txt
# S push[3:0] req0 req1 req2 req3 ready[3:0] : one cycle, masks binary with client 3 leftmost
# E winner : next expected winner_req in hex, src_tile equals the pushing client
# single client 3, three items at full rate
S 1000 00000000 00000000 00000000 0D400001 1111
S 1000 00000000 00000000 00000000 4D400002 1111
S 1000 00000000 00000000 00000000 8D400003 1111
S 0000 00000000 00000000 00000000 00000000 1111
E 0D400001
E 4D400002
E 8D400003
# load all clients with ready low, client 0 fills up
S 1111 01400010 45400011 89400012 CD400013 0000
S 0011 41400014 85400015 00000000 00000000 0000
S 0001 81400016 00000000 00000000 00000000 0000
S 0001 C1400017 00000000 00000000 00000000 0000
S 0000 00000000 00000000 00000000 00000000 0000
# drain with one ready bit at a time, empty clients skipped
S 0000 00000000 00000000 00000000 00000000 0100
S 0000 00000000 00000000 00000000 00000000 0100
S 0000 00000000 00000000 00000000 00000000 1000
S 0000 00000000 00000000 00000000 00000000 0001
S 0000 00000000 00000000 00000000 00000000 0010
S 0000 00000000 00000000 00000000 00000000 0010
S 0000 00000000 00000000 00000000 00000000 1000
S 0000 00000000 00000000 00000000 00000000 0001
E 01400010
E 45400011
E 89400012
E CD400013
E 41400014
E 85400015
E 81400016
E C1400017
# mixed traffic, push and pop on client 2 together, varied fields
S 0100 00000000 00000000 CA80BEEF 00000000 1111
S 0100 00000000 00000000 4A812345 00000000 1111
S 0110 00000000 C68ABCDE 8A855555 00000000 1111
S 0001 83FFFFFF 00000000 00000000 00000000 0010
S 0000 00000000 00000000 00000000 00000000 1111
S 0000 00000000 00000000 00000000 00000000 1111
S 0000 00000000 00000000 00000000 00000000 1111
E CA80BEEF
E 4A812345
E C68ABCDE
E 8A855555
E 83FFFFFF

//--- verification/tb_fifo_arb.sv
// testbench for the merge stage, replays the golden file one cycle per stimulus line
// checks every winner in order and each out_ready against a per-client occupancy model
`timescale 1ns/1ps

module tb_fifo_arb;
    import router_pkg::*;

    localparam int    MAX_STIM = 64;
    localparam int    MAX_EXP  = 64;
    localparam string GOLDEN   = "verification/fifo_arb_golden.txt";

    logic                   clk;
    logic                   rst_n = 1'b1;       // dropped at 1 ns for a clean reset edge
    logic [NUM_CLIENTS-1:0] push_v;             // per-client push strobes
    tile_trans_t            req_d [NUM_CLIENTS];
    logic [NUM_CLIENTS-1:0] ready_v;            // downstream ready levels
    logic [NUM_CLIENTS-1:0] out_ready_v;
    tile_trans_t            winner_req;
    logic                   winner_req_valid;

    // golden file contents
    logic [NUM_CLIENTS-1:0] stim_push  [MAX_STIM];
    logic [31:0]            stim_data  [MAX_STIM][NUM_CLIENTS];
    logic [NUM_CLIENTS-1:0] stim_ready [MAX_STIM];
    logic [31:0]            exp_mem    [MAX_EXP];   // expected winners, in order
    int num_stim;
    int num_exp;
    int exp_idx;                                    // next expected winner
    int occ [NUM_CLIENTS];                          // predicted FIFO fill per client
    int errors;
    int load_errors;
    int checks;
    int cycle_cnt;
    int limit;

    fifo_arb i_fifo_arb (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_alloc_req0 (push_v[0]),
        .valid_alloc_req1 (push_v[1]),
        .valid_alloc_req2 (push_v[2]),
        .valid_alloc_req3 (push_v[3]),
        .alloc_req0       (req_d[0]),
        .alloc_req1       (req_d[1]),
        .alloc_req2       (req_d[2]),
        .alloc_req3       (req_d[3]),
        .out_ready0       (out_ready_v[0]),
        .out_ready1       (out_ready_v[1]),
        .out_ready2       (out_ready_v[2]),
        .out_ready3       (out_ready_v[3]),
        .winner_req       (winner_req),
        .winner_req_valid (winner_req_valid),
        .in_ready0        (ready_v[0]),
        .in_ready1        (ready_v[1]),
        .in_ready2        (ready_v[2]),
        .in_ready3        (ready_v[3])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // ==================================================
    // golden file loading and stimulus
    // ==================================================
    task automatic load_golden();
        int                     fd;
        int                     n;
        string                  line;
        byte                    tag;
        logic [NUM_CLIENTS-1:0] pm;
        logic [NUM_CLIENTS-1:0] rm;
        logic [31:0]            d [NUM_CLIENTS];
        logic [31:0]            e;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            $display("cannot open golden file %s", GOLDEN);
            load_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1) begin
                tag = line.getc(0);              // comment lines match neither tag
                if (tag == "S") begin
                    n = $sscanf(line, "S %b %h %h %h %h %b", pm, d[0], d[1], d[2], d[3], rm);
                    if (n != 6 || num_stim >= MAX_STIM) begin
                        $display("unreadable stimulus line: %s", line);
                        load_errors++;
                    end else begin
                        stim_push[num_stim]  = pm;
                        stim_ready[num_stim] = rm;
                        for (int k = 0; k < NUM_CLIENTS; k++) stim_data[num_stim][k] = d[k];
                        num_stim++;
                    end
                end else if (tag == "E") begin
                    n = $sscanf(line, "E %h", e);
                    if (n != 1 || num_exp >= MAX_EXP) begin
                        $display("unreadable expected line: %s", line);
                        load_errors++;
                    end else begin
                        exp_mem[num_exp] = e;
                        num_exp++;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_stim(input int i);
        push_v  = stim_push[i];
        ready_v = stim_ready[i];
        for (int k = 0; k < NUM_CLIENTS; k++) req_d[k] = stim_data[i][k];
    endtask

    initial begin
        num_stim    = 0;
        num_exp     = 0;
        load_errors = 0;
        push_v      = '0;
        ready_v     = '0;
        for (int k = 0; k < NUM_CLIENTS; k++) req_d[k] = '0;
        load_golden();
        limit = 2 * num_stim + 20;
        #1 rst_n = 1'b0;
        repeat (3) @(negedge clk);          // reset spans three rising edges
        rst_n = 1'b1;
        for (int i = 0; i < num_stim; i++) begin
            drive_stim(i);                  // inputs change on the falling edge only
            @(negedge clk);
        end
        push_v  = '0;
        ready_v = '1;                       // drain anything still queued
        while (exp_idx < num_exp) @(negedge clk);
        repeat (3) @(negedge clk);          // room for stray pulses
        $display("done: %0d winners checked, %0d errors, %0d load errors",
                 checks, errors, load_errors);
        if (errors == 0 && load_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // ==================================================
    // output checking, pre-edge values at each rising edge
    // ==================================================
    always @(posedge clk) begin : check_outputs
        logic exp_rdy;
        if (!rst_n) begin
            if (winner_req_valid !== 1'b0) begin
                $display("MISMATCH t=%0t winner_req_valid expected 0 actual %b",
                         $time, winner_req_valid);
                errors++;
            end
            if (out_ready_v !== '1) begin
                $display("MISMATCH t=%0t out_ready expected 1111 actual %b", $time, out_ready_v);
                errors++;
            end
        end else begin
            if (winner_req_valid) begin
                if (exp_idx >= num_exp) begin
                    $display("t=%0t valid pulse with no expected winner left, got %h",
                             $time, winner_req);
                    errors++;
                end else begin
                    if (winner_req !== exp_mem[exp_idx]) begin
                        $display("MISMATCH t=%0t winner_req expected %h actual %h",
                                 $time, exp_mem[exp_idx], winner_req);
                        errors++;
                    end
                    exp_idx++;
                    checks++;
                end
                // src_tile carries the client number in the golden data
                if (occ[winner_req.src_tile[CLIENT_ID_W-1:0]] > 0)
                    occ[winner_req.src_tile[CLIENT_ID_W-1:0]]--;
            end
            for (int k = 0; k < NUM_CLIENTS; k++) begin
                exp_rdy = (occ[k] < FIFO_DEPTH);
                if (out_ready_v[k] !== exp_rdy) begin
                    $display("MISMATCH t=%0t out_ready%0d expected %b actual %b",
                             $time, k, exp_rdy, out_ready_v[k]);
                    errors++;
                end
                if (push_v[k]) occ[k]++;   // lands at this edge
            end
        end
    end

    initial begin : watchdog
        errors    = 0;
        checks    = 0;
        exp_idx   = 0;
        cycle_cnt = 0;
        for (int k = 0; k < NUM_CLIENTS; k++) occ[k] = 0;
        @(posedge clk);
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d expected winners never appeared, %0d errors",
                 cycle_cnt, num_exp - exp_idx, errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
